// ==== Makefile ====
TOP = ecc_sign_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
source/ecc_sign_pkg.sv
source/ecc_seq_rom.sv
source/ecc_sequencer.sv
source/ecc_operand_sel.sv
source/ecc_mod_alu.sv
source/ecc_range_check.sv
source/ecc_sign_top.sv
tb/ecc_sign_checks.sv
tb/ecc_sign_tb.sv

// ==== source/ecc_mod_alu.sv ====
module ecc_mod_alu (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  ecc_sign_pkg::opcode_t   op_i,
    input  ecc_sign_pkg::mem_addr_t addr_a_i,
    input  ecc_sign_pkg::mem_addr_t addr_b_i,
    input  ecc_sign_pkg::mem_addr_t addr_d_i,
    input  ecc_sign_pkg::word_t     wr_data_i,
    output ecc_sign_pkg::word_t     rd_data_o,
    output logic                    busy_o
);
    import ecc_sign_pkg::*;

    word_t     mem [2**MEM_ADDR_W];
    word_t     opa;
    word_t     opb;
    word_t     add_res;
    word_t     sub_res;
    word_t     mul_a;
    word_t     mul_b;
    word_t     mul_acc;
    word_t     mul_dbl;
    word_t     mul_step;
    mem_addr_t mul_dst;
    logic [$clog2(WORD_W)-1:0] mul_cnt;
    logic      mul_start;
    logic      mul_last;
    logic      wr_en;
    mem_addr_t wr_addr;
    word_t     wr_val;

    // x < 2q, one conditional subtraction brings it below q
    function automatic word_t reduce_once(input logic [WORD_W:0] x);
        logic [WORD_W:0] y;
        y = x - {1'b0, GROUP_ORDER};
        return (x >= {1'b0, GROUP_ORDER}) ? y[WORD_W-1:0] : x[WORD_W-1:0];
    endfunction

    assign opa       = mem[addr_a_i];
    assign opb       = mem[addr_b_i];
    assign rd_data_o = opa;

    // --------------------------------------------------
    // add, subtract and one multiply step
    // --------------------------------------------------
    always_comb begin
        add_res = reduce_once({1'b0, opa} + {1'b0, opb});
        sub_res = opa - opb;
        if (opa < opb) begin
            sub_res = sub_res + GROUP_ORDER;
        end
        // MSB first: acc = 2*acc + b[i]*a
        mul_dbl  = reduce_once({mul_acc, 1'b0});
        mul_step = reduce_once({1'b0, mul_dbl} + (mul_b[WORD_W-1] ? {1'b0, mul_a} : '0));
    end

    assign mul_start = (op_i == OP_MUL) && !busy_o;
    // counter wraps after WORD_W steps, last step is all ones
    assign mul_last  = busy_o && (&mul_cnt);

    // write port select, multiply writeback wins
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = addr_d_i;
        wr_val  = wr_data_i;
        if (mul_last) begin
            wr_en   = 1'b1;
            wr_addr = mul_dst;
            wr_val  = mul_step;
        end else begin
            case (op_i)
                OP_LOAD: wr_en = 1'b1;
                OP_ADD: begin
                    wr_en  = 1'b1;
                    wr_val = add_res;
                end
                OP_SUB: begin
                    wr_en  = 1'b1;
                    wr_val = sub_res;
                end
                default: wr_en = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            for (int i = 0; i < 2**MEM_ADDR_W; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_val;
        end
    end

    // multiplier operands and accumulator
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_a   <= opa;
            mul_b   <= opb;
            mul_acc <= '0;
            mul_dst <= addr_d_i;
        end else if (busy_o) begin
            mul_acc <= mul_step;
            mul_b   <= {mul_b[WORD_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_o  <= 1'b0;
            mul_cnt <= '0;
        end else if (zeroize_i) begin
            busy_o  <= 1'b0;
            mul_cnt <= '0;
        end else if (mul_start) begin
            busy_o  <= 1'b1;
            mul_cnt <= '0;
        end else if (busy_o) begin
            mul_cnt <= mul_cnt + 1'b1;
            if (mul_last) begin
                busy_o <= 1'b0;
            end
        end
    end

    // every stored value is a field element, loads included
    assert property (@(posedge clk) disable iff (!reset_n)
        wr_en |-> (wr_val < GROUP_ORDER));

endmodule

// ==== source/ecc_operand_sel.sv ====
module ecc_operand_sel (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  accept_i,
    input  ecc_sign_pkg::word_t   privkey_i,
    input  ecc_sign_pkg::word_t   sig_r_i,
    input  ecc_sign_pkg::word_t   msg_i,
    input  ecc_sign_pkg::opcode_t op_i,
    input  ecc_sign_pkg::src_id_t src_i,
    input  ecc_sign_pkg::word_t   rd_data_i,
    output ecc_sign_pkg::word_t   wr_data_o,
    output ecc_sign_pkg::word_t   sig_s_o,
    output logic                  s_we_o
);
    import ecc_sign_pkg::*;

    word_t priv_q;
    word_t r_q;
    word_t msg_red_q;
    word_t lfsr_q;
    word_t lfsr_next;
    word_t mask;

    // --------------------------------------------------
    // command operands
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            priv_q    <= '0;
            r_q       <= '0;
            msg_red_q <= '0;
        end else if (accept_i) begin
            priv_q    <= privkey_i;
            r_q       <= sig_r_i;
            // 2q > 2^32, one subtraction always lands below q
            msg_red_q <= (msg_i >= GROUP_ORDER) ? msg_i - GROUP_ORDER : msg_i;
        end
    end

    // --------------------------------------------------
    // mask source, fresh value per command
    // --------------------------------------------------
    assign lfsr_next = {1'b0, lfsr_q[WORD_W-1:1]} ^ (lfsr_q[0] ? LFSR_TAPS : '0);
    assign mask      = (lfsr_q >= GROUP_ORDER) ? lfsr_q - GROUP_ORDER : lfsr_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr_q <= LFSR_SEED;
        end else if (zeroize_i) begin
            lfsr_q <= LFSR_SEED;
        end else if (accept_i) begin
            lfsr_q <= lfsr_next;
        end
    end

    // load data for the operand memory
    always_comb begin
        wr_data_o = '0;
        if (op_i == OP_LOAD) begin
            case (src_i)
                SRC_MSG:  wr_data_o = msg_red_q;
                SRC_PRIV: wr_data_o = priv_q;
                SRC_R:    wr_data_o = r_q;
                default:  wr_data_o = mask;
            endcase
        end
    end

    // result register, s_we_o marks the cycle the new s is visible
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sig_s_o <= '0;
            s_we_o  <= 1'b0;
        end else if (zeroize_i) begin
            sig_s_o <= '0;
            s_we_o  <= 1'b0;
        end else begin
            s_we_o <= (op_i == OP_STORE);
            if (accept_i) begin
                sig_s_o <= '0;
            end else if (op_i == OP_STORE) begin
                sig_s_o <= rd_data_i;
            end
        end
    end

endmodule

// ==== source/ecc_range_check.sv ====
module ecc_range_check (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                accept_i,
    input  ecc_sign_pkg::word_t privkey_i,
    input  ecc_sign_pkg::word_t sig_r_i,
    input  logic                s_we_i,
    input  ecc_sign_pkg::word_t sig_s_i,
    output logic                input_bad_o,
    output logic                error_o
);
    import ecc_sign_pkg::*;

    logic priv_bad;
    logic r_bad;

    // --------------------------------------------------
    // input bounds, both must lie in [1, q-1]
    // --------------------------------------------------
    assign priv_bad    = (privkey_i == '0) || (privkey_i >= GROUP_ORDER);
    assign r_bad       = (sig_r_i == '0) || (sig_r_i >= GROUP_ORDER);
    assign input_bad_o = priv_bad || r_bad;

    // sticky per command, cleared by the next accept
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            error_o <= 1'b0;
        end else if (zeroize_i) begin
            error_o <= 1'b0;
        end else if (accept_i) begin
            error_o <= input_bad_o;
        end else if (s_we_i && (sig_s_i == '0)) begin
            // zero proof is not a valid signature
            error_o <= 1'b1;
        end
    end

endmodule

// ==== source/ecc_seq_rom.sv ====
module ecc_seq_rom (
    input  ecc_sign_pkg::prog_addr_t pc_i,
    output ecc_sign_pkg::opcode_t    op_o,
    output ecc_sign_pkg::src_id_t    src_o,
    output ecc_sign_pkg::mem_addr_t  addr_a_o,
    output ecc_sign_pkg::mem_addr_t  addr_b_o,
    output ecc_sign_pkg::mem_addr_t  addr_d_o
);
    import ecc_sign_pkg::*;

    // one instruction word is {op, src, a, b, dst}
    logic [$bits(opcode_t)+$bits(src_id_t)+3*MEM_ADDR_W-1:0] instr;

    // memory map: 0 h, 1 d, 2 r, 3 m, 4..6 scratch
    always_comb begin
        case (pc_i)
            // operand loads
            4'd0:    instr = {OP_LOAD,  SRC_MSG,  3'd0, 3'd0, 3'd0};
            4'd1:    instr = {OP_LOAD,  SRC_PRIV, 3'd0, 3'd0, 3'd1};
            4'd2:    instr = {OP_LOAD,  SRC_R,    3'd0, 3'd0, 3'd2};
            4'd3:    instr = {OP_LOAD,  SRC_MASK, 3'd0, 3'd0, 3'd3};
            // masked share: (d - m) * r + (h - m)
            4'd4:    instr = {OP_SUB,   SRC_MSG,  3'd1, 3'd3, 3'd4};
            4'd5:    instr = {OP_SUB,   SRC_MSG,  3'd0, 3'd3, 3'd5};
            4'd6:    instr = {OP_MUL,   SRC_MSG,  3'd4, 3'd2, 3'd4};
            4'd7:    instr = {OP_ADD,   SRC_MSG,  3'd4, 3'd5, 3'd4};
            // mask share: m * r + m
            4'd8:    instr = {OP_MUL,   SRC_MSG,  3'd3, 3'd2, 3'd5};
            4'd9:    instr = {OP_ADD,   SRC_MSG,  3'd5, 3'd3, 3'd5};
            // recombine and hand s out
            4'd10:   instr = {OP_ADD,   SRC_MSG,  3'd4, 3'd5, 3'd6};
            4'd11:   instr = {OP_STORE, SRC_MSG,  3'd6, 3'd0, 3'd0};
            4'd12:   instr = {OP_END,   SRC_MSG,  3'd0, 3'd0, 3'd0};
            // unused slots end the program
            default: instr = {OP_END,   SRC_MSG,  3'd0, 3'd0, 3'd0};
        endcase
    end

    assign {op_o, src_o, addr_a_o, addr_b_o, addr_d_o} = instr;

endmodule

// ==== source/ecc_sequencer.sv ====
module ecc_sequencer (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  logic                    cmd_valid_i,
    input  logic                    res_ready_i,
    input  logic                    input_bad_i,
    input  logic                    alu_busy_i,
    output logic                    cmd_ready_o,
    output logic                    accept_o,
    output logic                    res_valid_o,
    output ecc_sign_pkg::opcode_t   op_o,
    output ecc_sign_pkg::src_id_t   src_o,
    output ecc_sign_pkg::mem_addr_t addr_a_o,
    output ecc_sign_pkg::mem_addr_t addr_b_o,
    output ecc_sign_pkg::mem_addr_t addr_d_o
);
    import ecc_sign_pkg::*;

    seq_state_e state;
    prog_addr_t pc;
    opcode_t    rom_op;
    logic       res_take;

    ecc_seq_rom i_ecc_seq_rom (
        .pc_i     (pc),
        .op_o     (rom_op),
        .src_o    (src_o),
        .addr_a_o (addr_a_o),
        .addr_b_o (addr_b_o),
        .addr_d_o (addr_d_o)
    );

    assign cmd_ready_o = (state == S_IDLE);
    assign accept_o    = cmd_ready_o && cmd_valid_i;
    assign res_take    = res_valid_o && res_ready_i;

    // the datapath only sees an instruction while the program runs
    assign op_o = (state == S_RUN) ? rom_op : OP_NOP;

    // --------------------------------------------------
    // command FSM and program counter
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= S_IDLE;
            pc          <= '0;
            res_valid_o <= 1'b0;
        end else if (zeroize_i) begin
            state       <= S_IDLE;
            pc          <= '0;
            res_valid_o <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept_o) begin
                        pc    <= '0;
                        // bad inputs skip the program entirely
                        state <= input_bad_i ? S_RESULT : S_RUN;
                    end
                end
                S_RUN: begin
                    if (rom_op == OP_MUL) begin
                        state <= S_WAIT_ALU;
                    end else if (rom_op == OP_END) begin
                        state <= S_RESULT;
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
                S_WAIT_ALU: begin
                    // stall until the multiplier has written back
                    if (!alu_busy_i) begin
                        state <= S_RUN;
                        pc    <= pc + 1'b1;
                    end
                end
                S_RESULT: begin
                    // valid comes up one cycle after entry so s and error settle first
                    res_valid_o <= !res_take;
                    if (res_take) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // no new command may slip in while a result is pending
    assert property (@(posedge clk) disable iff (!reset_n)
        res_valid_o |-> !cmd_ready_o);

    // an instruction only issues while the ALU is idle
    assert property (@(posedge clk) disable iff (!reset_n)
        (op_o != OP_NOP) |-> !alu_busy_i);

endmodule

// ==== source/ecc_sign_pkg.sv ====
package ecc_sign_pkg;

    // --------------------------------------------------
    // widths and field constants
    // --------------------------------------------------
    localparam int WORD_W = 32;
    typedef logic [WORD_W-1:0] word_t;

    // group order q = 2^32 - 5
    localparam word_t GROUP_ORDER = 32'hffff_fffb;

    localparam int MEM_ADDR_W  = 3;
    localparam int PROG_ADDR_W = 4;

    typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
    typedef logic [PROG_ADDR_W-1:0] prog_addr_t;

    // mask generator, x^32 + x^22 + x^2 + x + 1 in Galois form
    localparam word_t LFSR_SEED = 32'h1d87_2b41;
    localparam word_t LFSR_TAPS = 32'h8020_0003;

    // --------------------------------------------------
    // microcode opcodes
    // --------------------------------------------------
    typedef logic [2:0] opcode_t;

    localparam opcode_t OP_NOP   = 3'd0;
    localparam opcode_t OP_LOAD  = 3'd1;
    localparam opcode_t OP_ADD   = 3'd2;
    localparam opcode_t OP_SUB   = 3'd3;
    localparam opcode_t OP_MUL   = 3'd4;
    localparam opcode_t OP_STORE = 3'd5;
    localparam opcode_t OP_END   = 3'd6;

    // operand sources for OP_LOAD
    typedef logic [1:0] src_id_t;

    localparam src_id_t SRC_MSG  = 2'd0;
    localparam src_id_t SRC_PRIV = 2'd1;
    localparam src_id_t SRC_R    = 2'd2;
    localparam src_id_t SRC_MASK = 2'd3;

    // --------------------------------------------------
    // sequencer states
    // --------------------------------------------------
    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_WAIT_ALU,
        S_RESULT
    } seq_state_e;

endpackage

// ==== source/ecc_sign_top.sv ====
module ecc_sign_top (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  ecc_sign_pkg::word_t privkey_i,
    input  ecc_sign_pkg::word_t sig_r_i,
    input  ecc_sign_pkg::word_t msg_i,
    output logic                res_valid_o,
    input  logic                res_ready_i,
    output ecc_sign_pkg::word_t sig_s_o,
    output logic                error_o
);
    import ecc_sign_pkg::*;

    logic      accept;
    logic      input_bad;
    logic      alu_busy;
    logic      s_we;
    opcode_t   op;
    src_id_t   src;
    mem_addr_t addr_a;
    mem_addr_t addr_b;
    mem_addr_t addr_d;
    word_t     rd_data;
    word_t     wr_data;

    // --------------------------------------------------
    // intake and sequencing
    // --------------------------------------------------
    ecc_sequencer i_ecc_sequencer (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .cmd_valid_i (cmd_valid_i),
        .res_ready_i (res_ready_i),
        .input_bad_i (input_bad),
        .alu_busy_i  (alu_busy),
        .cmd_ready_o (cmd_ready_o),
        .accept_o    (accept),
        .res_valid_o (res_valid_o),
        .op_o        (op),
        .src_o       (src),
        .addr_a_o    (addr_a),
        .addr_b_o    (addr_b),
        .addr_d_o    (addr_d)
    );

    ecc_range_check i_ecc_range_check (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .accept_i    (accept),
        .privkey_i   (privkey_i),
        .sig_r_i     (sig_r_i),
        .s_we_i      (s_we),
        .sig_s_i     (sig_s_o),
        .input_bad_o (input_bad),
        .error_o     (error_o)
    );

    // --------------------------------------------------
    // operand select and arithmetic
    // --------------------------------------------------
    ecc_operand_sel i_ecc_operand_sel (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .accept_i  (accept),
        .privkey_i (privkey_i),
        .sig_r_i   (sig_r_i),
        .msg_i     (msg_i),
        .op_i      (op),
        .src_i     (src),
        .rd_data_i (rd_data),
        .wr_data_o (wr_data),
        .sig_s_o   (sig_s_o),
        .s_we_o    (s_we)
    );

    ecc_mod_alu i_ecc_mod_alu (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .op_i      (op),
        .addr_a_i  (addr_a),
        .addr_b_i  (addr_b),
        .addr_d_i  (addr_d),
        .wr_data_i (wr_data),
        .rd_data_o (rd_data),
        .busy_o    (alu_busy)
    );

endmodule

// ==== tb/ecc_sign_checks.sv ====
module ecc_sign_checks (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          zeroize_i,
    input  logic          cmd_valid_i,
    input  logic          cmd_ready_i,
    input  logic [31:0]   privkey_i,
    input  logic [31:0]   sig_r_i,
    input  logic [31:0]   msg_i,
    input  logic          res_valid_i,
    input  logic          res_ready_i,
    input  logic [31:0]   sig_s_i,
    input  logic          error_i,
    input  logic [8*16-1:0] test_name_i,
    output logic          failed_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // group order q = 4294967291
    localparam logic [31:0] Q      = 32'd4294967291;
    localparam logic [63:0] Q_WIDE = 64'd4294967291;

    logic [31:0] exp_s;
    logic        exp_err;
    logic        pending;
    logic [31:0] held_s;
    logic        held_err;
    logic [3:0]  idle_flags;
    logic        hold_req;

    initial failed_o = 1'b0;

    function automatic logic in_range(input logic [31:0] v);
        return (v != 32'd0) && (v < Q);
    endfunction

    // unmasked proof (d*r + h) mod q
    function automatic logic [31:0] proof_value(input logic [31:0] d, input logic [31:0] r,
                                                input logic [31:0] h);
        logic [63:0] prod;
        logic [63:0] sum;
        prod = ({32'b0, d} * {32'b0, r}) % Q_WIDE;
        sum  = (prod + ({32'b0, h} % Q_WIDE)) % Q_WIDE;
        return sum[31:0];
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %0s: %0s expected %h actual %h",
                 test_name_i, what, expected, actual);
        failed_o = 1'b1;
    endtask

    task automatic report_event(input string what);
        $display("CHECK FAILED %0s: %0s", test_name_i, what);
        failed_o = 1'b1;
    endtask

    // --------------------------------------------------
    // reference model, one command in flight
    // --------------------------------------------------
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending <= 1'b0;
            exp_s   <= 32'd0;
            exp_err <= 1'b0;
        end else if (zeroize_i) begin
            pending <= 1'b0;
        end else if (cmd_valid_i && cmd_ready_i) begin
            pending <= 1'b1;
            if (in_range(privkey_i) && in_range(sig_r_i)) begin
                exp_s   <= proof_value(privkey_i, sig_r_i, msg_i);
                exp_err <= (proof_value(privkey_i, sig_r_i, msg_i) == 32'd0);
            end else begin
                exp_s   <= 32'd0;
                exp_err <= 1'b1;
            end
        end else if (res_valid_i && res_ready_i) begin
            pending <= 1'b0;
        end
    end

    always @(posedge clk) begin
        held_s   <= sig_s_i;
        held_err <= error_i;
    end

    assign idle_flags = {cmd_ready_i, res_valid_i, error_i, |sig_s_i};
    assign hold_req   = res_valid_i && !res_ready_i && !zeroize_i;

    // --------------------------------------------------
    // result checks
    // --------------------------------------------------
    assert property (@(posedge clk) disable iff (!reset_n)
        res_valid_i |-> (sig_s_i == exp_s))
        else report_mismatch("sig_s", exp_s, sig_s_i);

    assert property (@(posedge clk) disable iff (!reset_n)
        res_valid_i |-> (error_i == exp_err))
        else report_mismatch("error", 32'(exp_err), 32'(error_i));

    assert property (@(posedge clk) disable iff (!reset_n)
        res_valid_i |-> pending)
        else report_event("result appeared with no command in flight");

    // a waiting result stays put
    assert property (@(posedge clk) disable iff (!reset_n)
        hold_req |=> res_valid_i)
        else report_event("res_valid dropped before the result transferred");

    assert property (@(posedge clk) disable iff (!reset_n)
        hold_req |=> (sig_s_i == held_s))
        else report_mismatch("held sig_s", held_s, sig_s_i);

    assert property (@(posedge clk) disable iff (!reset_n)
        hold_req |=> (error_i == held_err))
        else report_mismatch("held error", 32'(held_err), 32'(error_i));

    assert property (@(posedge clk) disable iff (!reset_n)
        res_valid_i |-> !cmd_ready_i)
        else report_event("cmd_ready high while a result waits");

    // idle flags are {ready, valid, error, s nonzero}
    assert property (@(posedge clk) $rose(reset_n) |-> (idle_flags == 4'b1000))
        else report_mismatch("flags after reset", 32'h8, 32'(idle_flags));

    assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> (idle_flags == 4'b1000))
        else report_mismatch("flags after zeroize", 32'h8, 32'(idle_flags));

endmodule

// ==== tb/ecc_sign_tb.sv ====
module ecc_sign_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED           = 32'hc6ca_e450;
    localparam logic [31:0] Q              = 32'd4294967291;
    localparam int          CMD_BUDGET     = 60;
    localparam int          CYCLES_PER_CMD = 600;
    localparam int          TIMEOUT_CYCLES = CMD_BUDGET * CYCLES_PER_CMD;

    logic            clk;
    logic            reset_n;
    logic            zeroize;
    logic            cmd_valid;
    logic            cmd_ready;
    logic [31:0]     privkey;
    logic [31:0]     sig_r;
    logic [31:0]     msg;
    logic            res_valid;
    logic            res_ready;
    logic [31:0]     sig_s;
    logic            error;
    logic            check_failed;
    logic [8*16-1:0] test_name;
    int              cycle_count = 0;

    ecc_sign_top i_ecc_sign_top (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize),
        .cmd_valid_i (cmd_valid),
        .cmd_ready_o (cmd_ready),
        .privkey_i   (privkey),
        .sig_r_i     (sig_r),
        .msg_i       (msg),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready),
        .sig_s_o     (sig_s),
        .error_o     (error)
    );

    ecc_sign_checks i_ecc_sign_checks (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize),
        .cmd_valid_i (cmd_valid),
        .cmd_ready_i (cmd_ready),
        .privkey_i   (privkey),
        .sig_r_i     (sig_r),
        .msg_i       (msg),
        .res_valid_i (res_valid),
        .res_ready_i (res_ready),
        .sig_s_i     (sig_s),
        .error_i     (error),
        .test_name_i (test_name),
        .failed_o    (check_failed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%0s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    always @(posedge check_failed) begin
        stop_with_failure("an assertion in the checker failed");
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout: run exceeded %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // --------------------------------------------------
    // stimulus helpers, all start and end on a falling edge
    // --------------------------------------------------
    function automatic logic [31:0] rand_field();
        return $urandom_range(32'hffff_fffa, 1);
    endfunction

    // h that makes d*r + h a multiple of q
    function automatic logic [31:0] cancelling_msg(input logic [31:0] d, input logic [31:0] r);
        logic [63:0] prod;
        prod = ({32'b0, d} * {32'b0, r}) % {32'b0, Q};
        return Q - prod[31:0];
    endfunction

    task automatic send_command(input logic [31:0] d, input logic [31:0] r,
                                input logic [31:0] h);
        while (!cmd_ready) @(negedge clk);
        cmd_valid = 1'b1;
        privkey   = d;
        sig_r     = r;
        msg       = h;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // res_ready stays low for a random stretch once the result shows up
    task automatic take_result(input int stall_max);
        int stall;
        stall = (stall_max > 0) ? int'($urandom_range(stall_max, 0)) : 0;
        while (!res_valid) @(negedge clk);
        repeat (stall) @(negedge clk);
        res_ready = 1'b1;
        @(negedge clk);
        res_ready = 1'b0;
    endtask

    task automatic run_signing(input logic [31:0] d, input logic [31:0] r,
                               input logic [31:0] h, input int stall_max);
        send_command(d, r, h);
        take_result(stall_max);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] d;
        logic [31:0] r;
        test_name = "reset";
        reset_n   = 1'b0;
        zeroize   = 1'b0;
        cmd_valid = 1'b0;
        res_ready = 1'b0;
        privkey   = 32'd0;
        sig_r     = 32'd0;
        msg       = 32'd0;
        void'($urandom(SEED));
        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        repeat (2) @(negedge clk);

        test_name = "random_sign";
        for (int i = 0; i < 16; i++) begin
            run_signing(rand_field(), rand_field(), $urandom(), 0);
        end

        test_name = "msg_above_q";
        for (int i = 0; i < 6; i++) begin
            run_signing(rand_field(), rand_field(), Q + $urandom_range(4, 0), 0);
        end

        test_name = "bad_inputs";
        run_signing(32'd0, rand_field(), $urandom(), 0);
        run_signing(Q, rand_field(), $urandom(), 0);
        run_signing(32'hffff_ffff, rand_field(), $urandom(), 0);
        run_signing(rand_field(), 32'd0, $urandom(), 0);
        run_signing(rand_field(), Q + 32'd1, $urandom(), 0);
        run_signing(32'd0, 32'hffff_fffc, $urandom(), 0);

        test_name = "zero_proof";
        for (int i = 0; i < 4; i++) begin
            d = rand_field();
            r = rand_field();
            run_signing(d, r, cancelling_msg(d, r), 0);
        end

        test_name = "back_pressure";
        for (int i = 0; i < 10; i++) begin
            run_signing(rand_field(), rand_field(), $urandom(), 25);
        end

        test_name = "zeroize";
        for (int i = 0; i < 4; i++) begin
            send_command(rand_field(), rand_field(), $urandom());
            repeat ($urandom_range(70, 3)) @(negedge clk);
            zeroize = 1'b1;
            @(negedge clk);
            zeroize = 1'b0;
            // the dropped command must stay silent
            repeat (120) @(negedge clk);
            run_signing(rand_field(), rand_field(), $urandom(), 0);
        end

        repeat (4) @(negedge clk);
        if (check_failed) begin
            stop_with_failure("checker reported a failure");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule
